// File: rtl/ldpc_pkg.sv
// ====================================================================
// Shared definitions for the layered min-sum LDPC decoder.
// Holds the code dimensions, the base-graph shifts, the LLR types and
// the controller states. RTL files import it by wildcard.
// ====================================================================

package ldpc_pkg;

    // ====================================================================
    // Code dimensions
    // ====================================================================
    localparam int LIFT_Z   = 8;
    localparam int NUM_ROWS = 2;
    localparam int NUM_COLS = 4;
    localparam int CODE_N   = NUM_COLS * LIFT_Z;

    // Quantization, symmetric saturation
    localparam int LLR_W   = 6;
    localparam int LLR_MAX = 31;

    // ====================================================================
    // Types
    // ====================================================================
    typedef logic signed [LLR_W-1:0]  llr_t;
    // Lane i of a column sits in bits [i*LLR_W +: LLR_W]
    typedef logic [LIFT_Z*LLR_W-1:0]  llr_vec_t;
    typedef logic [LIFT_Z-1:0]        bit_vec_t;
    typedef logic [2:0]               shift_t;
    typedef logic [3:0]               iter_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        LAYER,
        CHECK,
        RESULT
    } ctrl_state_t;

    // Edge (r, j) links lane i of row r to lane (i + shift) mod Z of column j
    localparam shift_t SHIFT_TABLE [NUM_ROWS][NUM_COLS] = '{
        '{3'd0, 3'd1, 3'd2, 3'd3},
        '{3'd0, 3'd3, 3'd5, 3'd7}
    };

    // Clamp a one-bit-wider sum back into the LLR range
    function automatic llr_t sat_llr(input logic signed [LLR_W:0] v);
        llr_t res;
        if (v > LLR_MAX) begin
            res = llr_t'(LLR_MAX);
        end else if (v < -LLR_MAX) begin
            res = llr_t'(-LLR_MAX);
        end else begin
            res = v[LLR_W-1:0];
        end
        return res;
    endfunction

endpackage : ldpc_pkg

// File: rtl/layer_bus_if.sv
// ====================================================================
// Layer bus between the APP memory and the layer unit.
// Carries all four columns out for reading and back for the write.
// ====================================================================
`timescale 1ns/1ps

interface layer_bus_if import ldpc_pkg::*; ();

    // Active check row, driven by the controller
    logic                     layer;
    llr_vec_t [NUM_COLS-1:0]  rd_data;
    llr_vec_t [NUM_COLS-1:0]  wr_data;
    logic                     wr_en;

    modport memory (
        output rd_data,
        input  wr_data,
        input  wr_en
    );

    modport unit (
        input  layer,
        input  rd_data,
        output wr_data,
        output wr_en
    );

endinterface : layer_bus_if

// File: rtl/decode_ctrl.sv
// ====================================================================
// Decoder controller: both four-phase handshakes, the layer schedule,
// the early-stop decision and the latched results.
// One iteration is 4 LAYER cycles (issue/write per row) plus 1 CHECK.
// ====================================================================
`timescale 1ns/1ps

module decode_ctrl import ldpc_pkg::*; #(
    parameter int NUM_ITER_MAX = 10
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_req,
    input  logic [1:0]         in_col,
    input  iter_t              max_iter,
    input  logic               out_ack,
    input  logic               syndrome_zero,
    input  logic [CODE_N-1:0]  hard_bits,
    output logic               in_ack,
    output logic               load_en,
    output logic [1:0]         load_col,
    output logic               layer,
    output logic               layer_go,
    output logic               msg_clear,
    output logic               out_req,
    output logic [CODE_N-1:0]  decoded,
    output iter_t              iterations_used,
    output logic               decode_success,
    output logic [15:0]        cycle_count
);

    ctrl_state_t          state;
    logic [1:0]           step;
    logic [NUM_COLS-1:0]  col_seen;
    iter_t                iter_cnt;
    iter_t                iter_limit;
    iter_t                iter_next;
    logic [15:0]          cyc_cnt;
    logic                 res_acked;
    logic                 finish;

    // Columns are taken while req is up and ack still low
    assign load_en   = (state == IDLE || state == LOAD) && in_req && !in_ack;
    assign load_col  = in_col;
    assign msg_clear = load_en && (in_col == 2'd0);

    // step[1] selects the row, step[0] is the write half of a layer
    assign layer    = step[1];
    assign layer_go = (state == LAYER) && !step[0];

    assign iter_next = iter_cnt + 1'b1;
    assign finish    = (state == CHECK) && (syndrome_zero || iter_next >= iter_limit);

    // ====================================================================
    // State machine and handshakes
    // ====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            step       <= '0;
            col_seen   <= '0;
            iter_cnt   <= '0;
            iter_limit <= '0;
            cyc_cnt    <= '0;
            in_ack     <= 1'b0;
            out_req    <= 1'b0;
            res_acked  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (load_en) begin
                        in_ack           <= 1'b1;
                        col_seen[in_col] <= 1'b1;
                        state            <= LOAD;
                    end
                end
                LOAD: begin
                    if (in_ack && !in_req) begin
                        in_ack <= 1'b0;
                        // Last ack falling starts the decode
                        if (&col_seen) begin
                            state    <= LAYER;
                            step     <= '0;
                            iter_cnt <= '0;
                            cyc_cnt  <= '0;
                            col_seen <= '0;
                        end
                    end else if (load_en) begin
                        in_ack           <= 1'b1;
                        col_seen[in_col] <= 1'b1;
                    end
                end
                LAYER: begin
                    step    <= step + 1'b1;
                    cyc_cnt <= cyc_cnt + 1'b1;
                    if (step == 2'd3) begin
                        state <= CHECK;
                    end
                end
                CHECK: begin
                    cyc_cnt <= cyc_cnt + 1'b1;
                    if (finish) begin
                        state <= RESULT;
                    end else begin
                        iter_cnt <= iter_next;
                        state    <= LAYER;
                    end
                end
                RESULT: begin
                    if (!out_req && !res_acked) begin
                        out_req <= 1'b1;
                    end else if (out_req && out_ack) begin
                        out_req   <= 1'b0;
                        res_acked <= 1'b1;
                    end else if (res_acked && !out_ack) begin
                        res_acked <= 1'b0;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            // Iteration limit comes with column 0, capped by the build
            if (msg_clear) begin
                iter_limit <= (max_iter > iter_t'(NUM_ITER_MAX)) ?
                              iter_t'(NUM_ITER_MAX) : max_iter;
            end
        end
    end

    // Results held stable for the whole output handshake
    always_ff @(posedge clk) begin
        if (finish) begin
            decoded         <= hard_bits;
            iterations_used <= iter_next;
            decode_success  <= syndrome_zero;
            cycle_count     <= cyc_cnt + 1'b1;
        end
    end

    // No iteration beyond the synthesized cap is ever run
    assert property (@(posedge clk) disable iff (!rst_n)
        (state == CHECK) |-> (iter_next <= iter_t'(NUM_ITER_MAX)));

endmodule : decode_ctrl

// File: rtl/app_memory.sv
// ====================================================================
// Posterior LLR storage, one register per base-graph column.
// Loaded column by column from the channel, then rewritten whole by
// the layer unit. Hard decisions are the sign bits.
// ====================================================================
`timescale 1ns/1ps

module app_memory import ldpc_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_en,
    input  logic [1:0]         load_col,
    input  llr_vec_t           in_llr,
    output logic [CODE_N-1:0]  hard_bits,
    layer_bus_if.memory        bus
);

    llr_vec_t [NUM_COLS-1:0] app;

    always_ff @(posedge clk) begin
        if (load_en) begin
            app[load_col] <= in_llr;
        end else if (bus.wr_en) begin
            app <= bus.wr_data;
        end
    end

    assign bus.rd_data = app;

    // Negative LLR decides a 1
    always_comb begin
        for (int j = 0; j < NUM_COLS; j++) begin
            for (int i = 0; i < LIFT_Z; i++) begin
                hard_bits[j*LIFT_Z + i] = app[j][i*LLR_W + LLR_W - 1];
            end
        end
    end

    // Channel loading and layer write-back never overlap
    assert property (@(posedge clk) disable iff (!rst_n)
        !(load_en && bus.wr_en));

endmodule : app_memory

// File: rtl/layer_unit.sv
// ====================================================================
// Single-cycle layer processor for normalized min-sum (alpha = 3/4).
// Reads all columns on layer_go, updates the row's edge messages and
// returns the new APP values on a registered write one cycle later.
// ====================================================================
`timescale 1ns/1ps

module layer_unit import ldpc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      layer_go,
    input  logic      msg_clear,
    layer_bus_if.unit bus
);

    // Edge messages kept in check-row lane order
    llr_vec_t [NUM_COLS-1:0] edge_msg [NUM_ROWS];
    llr_vec_t [NUM_COLS-1:0] next_msg;
    llr_vec_t [NUM_COLS-1:0] next_app;
    llr_vec_t [NUM_COLS-1:0] wr_data_q;
    logic                    wr_en_q;

    // ====================================================================
    // Check-node update per lane
    // ====================================================================
    always_comb begin
        llr_t              q [NUM_COLS];
        logic [LLR_W-2:0]  mag [NUM_COLS];
        llr_t              a;
        llr_t              r_old;
        llr_t              r_new;
        llr_t              abs_q;
        logic [LLR_W-2:0]  min1;
        logic [LLR_W-2:0]  min2;
        logic [LLR_W-2:0]  m_sel;
        logic [LLR_W:0]    scaled;
        logic [1:0]        min_idx;
        logic              sgn_prod;
        int                src;

        next_app = '0;
        next_msg = '0;
        for (int i = 0; i < LIFT_Z; i++) begin
            min1     = '1;
            min2     = '1;
            min_idx  = '0;
            sgn_prod = 1'b0;
            // Rotate into row order and strip the old edge message
            for (int j = 0; j < NUM_COLS; j++) begin
                src    = (i + int'(SHIFT_TABLE[bus.layer][j])) % LIFT_Z;
                a      = bus.rd_data[j][src*LLR_W +: LLR_W];
                r_old  = edge_msg[bus.layer][j][i*LLR_W +: LLR_W];
                q[j]   = sat_llr({a[LLR_W-1], a} - {r_old[LLR_W-1], r_old});
                abs_q  = q[j][LLR_W-1] ? -q[j] : q[j];
                mag[j] = abs_q[LLR_W-2:0];
                sgn_prod = sgn_prod ^ q[j][LLR_W-1];
                if (mag[j] < min1) begin
                    min2    = min1;
                    min1    = mag[j];
                    min_idx = 2'(j);
                end else if (mag[j] < min2) begin
                    min2 = mag[j];
                end
            end
            for (int j = 0; j < NUM_COLS; j++) begin
                m_sel = (j == min_idx) ? min2 : min1;
                // 3*m >> 2
                scaled = {2'b00, m_sel} + {1'b0, m_sel, 1'b0};
                r_new  = llr_t'({1'b0, scaled[LLR_W:2]});
                if (sgn_prod ^ q[j][LLR_W-1]) begin
                    r_new = -r_new;
                end
                next_msg[j][i*LLR_W +: LLR_W] = r_new;
                // Rotate back into column order
                src = (i + int'(SHIFT_TABLE[bus.layer][j])) % LIFT_Z;
                next_app[j][src*LLR_W +: LLR_W] =
                    sat_llr({q[j][LLR_W-1], q[j]} + {r_new[LLR_W-1], r_new});
            end
        end
    end

    always_ff @(posedge clk) begin
        if (msg_clear) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                edge_msg[r] <= '0;
            end
        end else if (layer_go) begin
            edge_msg[bus.layer] <= next_msg;
        end
        if (layer_go) begin
            wr_data_q <= next_app;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= layer_go;
        end
    end

    assign bus.wr_en   = wr_en_q;
    assign bus.wr_data = wr_data_q;

    // A new layer is never issued while a write-back is pending
    assert property (@(posedge clk) disable iff (!rst_n)
        bus.wr_en |-> !layer_go);

endmodule : layer_unit

// File: rtl/syndrome_check.sv
// ====================================================================
// Combinational syndrome of the current hard decisions.
// Evaluates all 16 parity checks of the lifted code.
// ====================================================================
`timescale 1ns/1ps

module syndrome_check import ldpc_pkg::*; (
    input  logic [CODE_N-1:0]  hard_bits,
    output logic               syndrome_zero
);

    bit_vec_t                    col_bits [NUM_COLS];
    logic [NUM_ROWS*LIFT_Z-1:0]  syn;

    // Split the codeword into columns
    always_comb begin
        for (int j = 0; j < NUM_COLS; j++) begin
            col_bits[j] = hard_bits[j*LIFT_Z +: LIFT_Z];
        end
    end

    // Check (r, i) sees lane (i + shift) mod Z of every column
    always_comb begin
        syn = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int i = 0; i < LIFT_Z; i++) begin
                for (int j = 0; j < NUM_COLS; j++) begin
                    syn[r*LIFT_Z + i] = syn[r*LIFT_Z + i] ^
                        col_bits[j][(i + int'(SHIFT_TABLE[r][j])) % LIFT_Z];
                end
            end
        end
    end

    assign syndrome_zero = ~|syn;

endmodule : syndrome_check

// File: rtl/ldpc_decoder_top.sv
// ====================================================================
// Top level of the QC-LDPC decoder (2x4 base graph, Z = 8).
// Frames enter one column per req/ack cycle; results leave on a
// second req/ack pair. NUM_ITER_MAX bounds the runtime max_iter.
// ====================================================================
`timescale 1ns/1ps

module ldpc_decoder_top import ldpc_pkg::*; #(
    parameter int NUM_ITER_MAX = 10
) (
    input  logic               clk,
    input  logic               rst_n,
    // Frame input
    input  logic               in_req,
    input  logic [1:0]         in_col,
    input  llr_vec_t           in_llr,
    input  iter_t              max_iter,
    output logic               in_ack,
    // Result output
    input  logic               out_ack,
    output logic               out_req,
    output logic [CODE_N-1:0]  decoded,
    output iter_t              iterations_used,
    output logic               decode_success,
    output logic [15:0]        cycle_count
);

    logic               load_en;
    logic [1:0]         load_col;
    logic               layer_go;
    logic               msg_clear;
    logic               syndrome_zero;
    logic [CODE_N-1:0]  hard_bits;

    layer_bus_if bus ();

    decode_ctrl #(
        .NUM_ITER_MAX (NUM_ITER_MAX)
    ) u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_req          (in_req),
        .in_col          (in_col),
        .max_iter        (max_iter),
        .out_ack         (out_ack),
        .syndrome_zero   (syndrome_zero),
        .hard_bits       (hard_bits),
        .in_ack          (in_ack),
        .load_en         (load_en),
        .load_col        (load_col),
        .layer           (bus.layer),
        .layer_go        (layer_go),
        .msg_clear       (msg_clear),
        .out_req         (out_req),
        .decoded         (decoded),
        .iterations_used (iterations_used),
        .decode_success  (decode_success),
        .cycle_count     (cycle_count)
    );

    app_memory u_app (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_col  (load_col),
        .in_llr    (in_llr),
        .hard_bits (hard_bits),
        .bus       (bus.memory)
    );

    layer_unit u_layer (
        .clk       (clk),
        .rst_n     (rst_n),
        .layer_go  (layer_go),
        .msg_clear (msg_clear),
        .bus       (bus.unit)
    );

    syndrome_check u_syn (
        .hard_bits     (hard_bits),
        .syndrome_zero (syndrome_zero)
    );

endmodule : ldpc_decoder_top

// File: test/ldpc_checker.sv
// ======================================================================
// Result checker for the LDPC decoder testbench.
// Watches both req/ack handshakes, captures each frame, runs a reference
// layered min-sum decoder and compares every result the DUT returns.
// ======================================================================
`timescale 1ns/1ps

module ldpc_checker import ldpc_pkg::*; #(
    parameter int NUM_ITER_MAX = 10
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_req,
    input  logic               in_ack,
    input  logic [1:0]         in_col,
    input  llr_vec_t           in_llr,
    input  iter_t              max_iter,
    input  logic               out_req,
    input  logic               out_ack,
    input  logic [CODE_N-1:0]  decoded,
    input  iter_t              iterations_used,
    input  logic               decode_success,
    input  logic [15:0]        cycle_count,
    output int                 frames,
    output int                 errors
);

    int                    chan [NUM_COLS][LIFT_Z];
    int                    limit;
    logic                  in_req_q;
    logic                  in_ack_q;
    logic                  out_req_q;
    logic                  out_ack_q;
    logic [CODE_N+20:0]    result_now;
    logic [CODE_N+20:0]    snap;

    assign result_now = {decoded, iterations_used, decode_success, cycle_count};

    function automatic int clamp_llr(input int v);
        if (v > 31) return 31;
        if (v < -31) return -31;
        return v;
    endfunction

    function automatic int lane_of(input llr_vec_t v, input int i);
        llr_t x;
        x = v[i*LLR_W +: LLR_W];
        return int'(x);
    endfunction

    // Every check row must see an even number of ones
    function automatic logic parity_ok(input logic [CODE_N-1:0] w);
        logic p;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int i = 0; i < LIFT_Z; i++) begin
                p = 1'b0;
                for (int j = 0; j < NUM_COLS; j++) begin
                    p ^= w[j*LIFT_Z + (i + int'(SHIFT_TABLE[r][j])) % LIFT_Z];
                end
                if (p) return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // ======================================================================
    // Reference decoder, rows in order 0 then 1
    // ======================================================================
    task automatic run_reference(output logic [CODE_N-1:0] dec, output int iters,
                                 output logic succ);
        int app [NUM_COLS][LIFT_Z];
        int msg [NUM_ROWS][NUM_COLS][LIFT_Z];
        int q [NUM_COLS];
        int m1;
        int m2;
        int idx;
        int neg;
        int src;
        int mag;
        int r_new;
        app = chan;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int j = 0; j < NUM_COLS; j++) begin
                for (int i = 0; i < LIFT_Z; i++) begin
                    msg[r][j][i] = 0;
                end
            end
        end
        iters = 0;
        do begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                for (int i = 0; i < LIFT_Z; i++) begin
                    m1 = 31;
                    m2 = 31;
                    idx = 0;
                    neg = 0;
                    for (int j = 0; j < NUM_COLS; j++) begin
                        src = (i + int'(SHIFT_TABLE[r][j])) % LIFT_Z;
                        q[j] = clamp_llr(app[j][src] - msg[r][j][i]);
                        mag = (q[j] < 0) ? -q[j] : q[j];
                        neg = neg ^ int'(q[j] < 0);
                        if (mag < m1) begin
                            m2 = m1;
                            m1 = mag;
                            idx = j;
                        end else if (mag < m2) begin
                            m2 = mag;
                        end
                    end
                    for (int j = 0; j < NUM_COLS; j++) begin
                        // alpha = 3/4
                        r_new = (3 * ((j == idx) ? m2 : m1)) >> 2;
                        if ((neg ^ int'(q[j] < 0)) != 0) r_new = -r_new;
                        msg[r][j][i] = r_new;
                        src = (i + int'(SHIFT_TABLE[r][j])) % LIFT_Z;
                        app[j][src] = clamp_llr(q[j] + r_new);
                    end
                end
            end
            iters++;
            for (int j = 0; j < NUM_COLS; j++) begin
                for (int i = 0; i < LIFT_Z; i++) begin
                    dec[j*LIFT_Z + i] = (app[j][i] < 0);
                end
            end
            succ = parity_ok(dec);
        end while (!succ && iters < limit);
    endtask

    task automatic check_val(input string name, input longint exp, input longint got);
        if (exp != got) begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        int                 err_before;
        int                 exp_iters;
        logic [CODE_N-1:0]  exp_dec;
        logic               exp_succ;
        logic               all_pos;
        if (!rst_n) begin
            in_req_q  = 1'b0;
            in_ack_q  = 1'b0;
            out_req_q = 1'b0;
            out_ack_q = 1'b0;
            frames    = 0;
            errors    = 0;
        end else begin
            // Column is taken on the rising ack
            if (in_ack && !in_ack_q) begin
                if (!in_req) begin
                    $display("Handshake error at %0t: in_ack rose while in_req was low", $time);
                    errors++;
                end
                for (int i = 0; i < LIFT_Z; i++) begin
                    chan[in_col][i] = lane_of(in_llr, i);
                end
                if (in_col == 2'd0) begin
                    limit = (max_iter > NUM_ITER_MAX) ? NUM_ITER_MAX : int'(max_iter);
                end
            end
            if (in_req_q && !in_req && !in_ack_q) begin
                $display("Handshake error at %0t: in_req dropped before in_ack", $time);
                errors++;
            end
            if (out_req_q && !out_req && !out_ack_q) begin
                $display("Handshake error at %0t: out_req dropped before out_ack", $time);
                errors++;
            end
            if (out_req && out_req_q && result_now != snap) begin
                $display("Handshake error at %0t: results changed while out_req was high",
                         $time);
                errors++;
            end
            if (out_req && !out_req_q) begin
                err_before = errors;
                snap = result_now;
                run_reference(exp_dec, exp_iters, exp_succ);
                check_val("decoded", exp_dec, decoded);
                check_val("iterations_used", exp_iters, iterations_used);
                check_val("decode_success", exp_succ, decode_success);
                check_val("decode_success vs syndrome", parity_ok(decoded), decode_success);
                check_val("cycle_count", 5 * exp_iters, cycle_count);
                if (limit == 1) begin
                    check_val("iterations_used at cap", 1, iterations_used);
                end
                all_pos = 1'b1;
                for (int j = 0; j < NUM_COLS; j++) begin
                    for (int i = 0; i < LIFT_Z; i++) begin
                        if (chan[j][i] <= 0) all_pos = 1'b0;
                    end
                end
                // Clean channel decodes to zeros in one pass
                if (all_pos) begin
                    check_val("decoded all-zero", 0, decoded);
                    check_val("iterations_used all-zero", 1, iterations_used);
                    check_val("decode_success all-zero", 1, decode_success);
                end
                frames++;
                $display("Frame %0d: %s (iterations %0d, success %0b, cycles %0d)", frames,
                         (errors == err_before) ? "ok" : "MISMATCH", iterations_used,
                         decode_success, cycle_count);
            end
            in_req_q  = in_req;
            in_ack_q  = in_ack;
            out_req_q = out_req;
            out_ack_q = out_ack;
        end
    end

endmodule : ldpc_checker

// File: test/tb_ldpc_decoder.sv
// ======================================================================
// Testbench for the LDPC decoder.
// Sends one clean frame and a run of random frames over the req/ack
// input, takes each result and leaves the comparing to the checker.
// ======================================================================
`timescale 1ns/1ps

module tb_ldpc_decoder import ldpc_pkg::*; ();

    localparam int NUM_ITER_MAX = 10;
    localparam int NUM_FRAMES   = 201;
    localparam int WAIT_LIMIT   = 200;

    logic               clk;
    logic               rst_n;
    logic               in_req;
    logic               in_ack;
    logic [1:0]         in_col;
    llr_vec_t           in_llr;
    iter_t              max_iter;
    logic               out_req;
    logic               out_ack;
    logic [CODE_N-1:0]  decoded;
    iter_t              iterations_used;
    logic               decode_success;
    logic [15:0]        cycle_count;
    int                 frames;
    int                 errors;
    logic               timed_out;
    llr_vec_t           frame_llr [NUM_COLS];
    iter_t              frame_iter;

    ldpc_decoder_top #(
        .NUM_ITER_MAX (NUM_ITER_MAX)
    ) UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_req          (in_req),
        .in_col          (in_col),
        .in_llr          (in_llr),
        .max_iter        (max_iter),
        .in_ack          (in_ack),
        .out_ack         (out_ack),
        .out_req         (out_req),
        .decoded         (decoded),
        .iterations_used (iterations_used),
        .decode_success  (decode_success),
        .cycle_count     (cycle_count)
    );

    ldpc_checker #(
        .NUM_ITER_MAX (NUM_ITER_MAX)
    ) u_check (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic wait_in_ack(input logic level);
        int n;
        n = 0;
        while (in_ack !== level && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (in_ack !== level) begin
            $display("Timeout: in_ack did not reach %0b within %0d cycles", level, WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_out_req(input logic level);
        int n;
        n = 0;
        while (out_req !== level && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (out_req !== level) begin
            $display("Timeout: out_req did not reach %0b within %0d cycles", level, WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    // Four-phase transfer of columns 0 to 3
    task automatic send_frame();
        for (int j = 0; j < NUM_COLS; j++) begin
            repeat ($urandom_range(3, 0)) @(posedge clk);
            in_col   <= 2'(j);
            in_llr   <= frame_llr[j];
            max_iter <= frame_iter;
            in_req   <= 1'b1;
            wait_in_ack(1'b1);
            in_req <= 1'b0;
            wait_in_ack(1'b0);
            if (timed_out) return;
        end
    endtask

    task automatic take_result();
        wait_out_req(1'b1);
        repeat ($urandom_range(3, 0)) @(posedge clk);
        out_ack <= 1'b1;
        wait_out_req(1'b0);
        out_ack <= 1'b0;
    endtask

    task automatic make_random_frame(input int n);
        int v;
        for (int j = 0; j < NUM_COLS; j++) begin
            for (int i = 0; i < LIFT_Z; i++) begin
                v = int'($urandom_range(62, 0)) - 31;
                frame_llr[j][i*LLR_W +: LLR_W] = llr_t'(v);
            end
        end
        // Some frames pinned to a single iteration
        frame_iter = (n % 10 == 0) ? iter_t'(1) : iter_t'($urandom_range(10, 1));
    endtask

    initial begin
        void'($urandom(32'h73283aec));
        rst_n     = 1'b0;
        in_req    = 1'b0;
        in_col    = '0;
        in_llr    = '0;
        max_iter  = iter_t'(1);
        out_ack   = 1'b0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // All-zero codeword with strong positive LLRs
        for (int j = 0; j < NUM_COLS; j++) begin
            frame_llr[j] = {LIFT_Z{6'd20}};
        end
        frame_iter = iter_t'(10);
        send_frame();
        if (!timed_out) take_result();

        for (int n = 1; n < NUM_FRAMES && !timed_out; n++) begin
            make_random_frame(n);
            send_frame();
            if (!timed_out) take_result();
        end
        repeat (2) @(posedge clk);

        $display("Summary: %0d of %0d frames checked, %0d errors, timeout %0b",
                 frames, NUM_FRAMES, errors, timed_out);
        if (timed_out || errors != 0 || frames != NUM_FRAMES) begin
            $display("sim failed");
        end else begin
            $display("sim passed");
        end
        $finish;
    end

endmodule : tb_ldpc_decoder

// File: src.f
rtl/ldpc_pkg.sv
rtl/layer_bus_if.sv
rtl/decode_ctrl.sv
rtl/app_memory.sv
rtl/layer_unit.sv
rtl/syndrome_check.sv
rtl/ldpc_decoder_top.sv
test/ldpc_checker.sv
test/tb_ldpc_decoder.sv

// File: run.sh
#!/bin/sh
# Build the LDPC decoder testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_ldpc_decoder -o sim_ldpc > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_ldpc > sim.log 2>&1

grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
